// ==== compile.f ====
design/runner_pkg.sv
design/uart_rx.sv
design/player_inputs.sv
design/player_motion.sv
design/world_scroller.sv
design/score_keeper.sv
design/score_display.sv
design/runner_top.sv
tests/runner_assertions.sv
tests/runner_checker.sv
tests/runner_tb.sv

// ==== design/player_inputs.sv ====
`timescale 1ns/1ns

module player_inputs (
	input logic Clock,
	input logic rst_n,
	input logic byte_valid,
	input logic [7:0] byte_data,
	input logic jump_key,
	input logic duck_key,
	output runner_pkg::player_cmd_t cmd
);

	// Bit 1 is the jump key, bit 0 the duck key
	logic [1:0] key_meta;
	logic [1:0] key_sync;
	logic [1:0] key_prev;
	logic [1:0] key_rise;

	assign key_rise = key_sync & ~key_prev;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			key_meta <= '0;
			key_sync <= '0;
			key_prev <= '0;
			cmd <= '0;
		end else begin
			key_meta <= {jump_key, duck_key};
			key_sync <= key_meta;
			key_prev <= key_sync;
			// Bytes other than J and D fall through
			cmd.jump <= key_rise[1] | (byte_valid && byte_data == "J");
			cmd.duck <= key_rise[0] | (byte_valid && byte_data == "D");
		end
	end

endmodule

// ==== design/player_motion.sv ====
`timescale 1ns/1ns

module player_motion #(
	parameter int DUCK_CYCLES = 50_000_000
) (
	input logic Clock,
	input logic rst_n,
	input runner_pkg::player_cmd_t cmd,
	input logic step,
	input logic game_over,
	output runner_pkg::coord_y_t dino_y,
	output logic ducking
);

	localparam int DW = $clog2(DUCK_CYCLES + 1);

	runner_pkg::jump_state_t state;
	runner_pkg::velocity_t vel;
	runner_pkg::velocity_t vel_next;
	logic [DW-1:0] duck_cnt;
	logic signed [10:0] next_y;

	assign ducking = (duck_cnt != '0);
	// Screen rows grow downward, so a negative speed rises
	assign next_y = $signed({3'b000, dino_y}) + $signed({vel[9], vel});
	assign vel_next = vel + runner_pkg::GRAVITY;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			duck_cnt <= '0;
		end else if (!game_over) begin
			if (cmd.duck && state == runner_pkg::JS_RUNNING && !ducking) begin
				duck_cnt <= DW'(DUCK_CYCLES);
			end else if (ducking) begin
				duck_cnt <= duck_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			state <= runner_pkg::JS_RUNNING;
			vel <= '0;
			dino_y <= runner_pkg::GROUND_Y;
		end else if (!game_over) begin
			if (cmd.jump && state == runner_pkg::JS_RUNNING && !ducking) begin
				vel <= runner_pkg::JUMP_FORCE;
				state <= runner_pkg::JS_ASCENDING;
			end else if (step && state != runner_pkg::JS_RUNNING) begin
				if (next_y >= $signed({3'b000, runner_pkg::GROUND_Y})) begin
					// Landed
					dino_y <= runner_pkg::GROUND_Y;
					vel <= '0;
					state <= runner_pkg::JS_RUNNING;
				end else begin
					dino_y <= next_y[7:0];
					vel <= vel_next;
					state <= (vel_next > 0) ? runner_pkg::JS_DESCENDING
						: runner_pkg::JS_ASCENDING;
				end
			end
		end
	end

endmodule

// ==== design/runner_pkg.sv ====
package runner_pkg;

	typedef logic [8:0] coord_x_t;
	typedef logic [7:0] coord_y_t;
	typedef logic signed [9:0] velocity_t;
	typedef logic [15:0] score_t;
	typedef logic [6:0] seg7_t;

	typedef enum logic [1:0] {JS_RUNNING, JS_ASCENDING, JS_DESCENDING} jump_state_t;
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	typedef struct packed {
		logic jump;
		logic duck;
	} player_cmd_t;

	// High-score digits sit in the upper bits, score ones in bits 6:0
	typedef struct packed {
		seg7_t high_hundreds;
		seg7_t high_tens;
		seg7_t high_ones;
		seg7_t score_hundreds;
		seg7_t score_tens;
		seg7_t score_ones;
	} hex_digits_t;

	localparam coord_x_t SCREEN_W = 9'd320;
	localparam coord_y_t GROUND_Y = 8'd109;
	localparam coord_x_t DINO_X = 9'd52;
	localparam coord_y_t OBS_Y = 8'd109;
	localparam int unsigned OBS_SIZE = 16;
	localparam velocity_t JUMP_FORCE = -10'sd10;
	localparam velocity_t GRAVITY = 10'sd1;

	// Dinosaur hitbox inside its 32x32 sprite
	localparam coord_x_t DINO_HB_X_OFS = 9'd6;
	localparam coord_y_t DINO_HB_Y_OFS = 8'd2;
	localparam coord_x_t DINO_HB_W = 9'd20;
	localparam coord_y_t DINO_HB_H = 8'd30;
	localparam coord_y_t DINO_HB_H_DUCK = 8'd15;

	localparam int unsigned RESPAWN_SPAN = 100;
	localparam logic [15:0] LFSR_SEED = 16'hACE1;

endpackage

// ==== design/runner_top.sv ====
`timescale 1ns/1ns

module runner_top #(
	parameter int CLK_HZ = 50_000_000,
	parameter int BAUD = 115_200,
	parameter int STEP_DIV = 524_288,
	parameter int DUCK_CYCLES = 50_000_000
) (
	input logic Clock,
	input logic rst_n,
	input logic uart_rx_line,
	input logic jump_key,
	input logic duck_key,
	output runner_pkg::coord_y_t dino_y,
	output runner_pkg::coord_x_t obstacle_x,
	output logic ducking,
	output logic game_over,
	output runner_pkg::hex_digits_t digits
);

	logic byte_valid;
	logic [7:0] byte_data;
	runner_pkg::player_cmd_t cmd;
	logic step;
	logic respawn;
	runner_pkg::score_t score;
	runner_pkg::score_t high_score;

	uart_rx #(
		.CLK_HZ(CLK_HZ),
		.BAUD(BAUD)
	) u_uart_rx (
		.Clock(Clock),
		.rst_n(rst_n),
		.rx_line(uart_rx_line),
		.byte_valid(byte_valid),
		.byte_data(byte_data)
	);

	player_inputs u_player_inputs (
		.Clock(Clock),
		.rst_n(rst_n),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.jump_key(jump_key),
		.duck_key(duck_key),
		.cmd(cmd)
	);

	player_motion #(
		.DUCK_CYCLES(DUCK_CYCLES)
	) u_player_motion (
		.Clock(Clock),
		.rst_n(rst_n),
		.cmd(cmd),
		.step(step),
		.game_over(game_over),
		.dino_y(dino_y),
		.ducking(ducking)
	);

	world_scroller #(
		.STEP_DIV(STEP_DIV)
	) u_world_scroller (
		.Clock(Clock),
		.rst_n(rst_n),
		.respawn(respawn),
		.game_over(game_over),
		.step(step),
		.obstacle_x(obstacle_x)
	);

	score_keeper u_score_keeper (
		.Clock(Clock),
		.rst_n(rst_n),
		.dino_y(dino_y),
		.obstacle_x(obstacle_x),
		.ducking(ducking),
		.game_over(game_over),
		.respawn(respawn),
		.score(score),
		.high_score(high_score)
	);

	score_display u_score_display (
		.score(score),
		.high_score(high_score),
		.digits(digits)
	);

endmodule

// ==== design/score_display.sv ====
`timescale 1ns/1ns

module score_display (
	input runner_pkg::score_t score,
	input runner_pkg::score_t high_score,
	output runner_pkg::hex_digits_t digits
);

	// Active-low segments, bit 6 is segment g
	function automatic runner_pkg::seg7_t seg_of(input logic [3:0] d);
		case (d)
			4'd0: seg_of = 7'b1000000;
			4'd1: seg_of = 7'b1111001;
			4'd2: seg_of = 7'b0100100;
			4'd3: seg_of = 7'b0110000;
			4'd4: seg_of = 7'b0011001;
			4'd5: seg_of = 7'b0010010;
			4'd6: seg_of = 7'b0000010;
			4'd7: seg_of = 7'b1111000;
			4'd8: seg_of = 7'b0000000;
			4'd9: seg_of = 7'b0010000;
			default: seg_of = 7'b1111111;
		endcase
	endfunction

	function automatic logic [3:0] digit_of(input runner_pkg::score_t v, input int unsigned div);
		digit_of = 4'((v / div) % 10);
	endfunction

	always_comb begin
		digits.score_ones = seg_of(digit_of(score, 1));
		digits.score_tens = seg_of(digit_of(score, 10));
		digits.score_hundreds = seg_of(digit_of(score, 100));
		digits.high_ones = seg_of(digit_of(high_score, 1));
		digits.high_tens = seg_of(digit_of(high_score, 10));
		digits.high_hundreds = seg_of(digit_of(high_score, 100));
	end

endmodule

// ==== design/score_keeper.sv ====
`timescale 1ns/1ns

module score_keeper (
	input logic Clock,
	input logic rst_n,
	input runner_pkg::coord_y_t dino_y,
	input runner_pkg::coord_x_t obstacle_x,
	input logic ducking,
	output logic game_over,
	output logic respawn,
	output runner_pkg::score_t score,
	output runner_pkg::score_t high_score
);

	logic [9:0] dino_l;
	logic [9:0] dino_r;
	logic [9:0] obs_l;
	logic [9:0] obs_r;
	logic [8:0] dino_t;
	logic [8:0] dino_b;
	logic [8:0] obs_t;
	logic [8:0] obs_b;
	runner_pkg::coord_y_t hb_h;
	logic hit;
	logic hit_q;
	logic crossing;
	logic game_over_q;
	runner_pkg::coord_x_t prev_x;
	runner_pkg::score_t best = '0;

	assign hb_h = ducking ? runner_pkg::DINO_HB_H_DUCK : runner_pkg::DINO_HB_H;
	assign dino_l = 10'(runner_pkg::DINO_X) + 10'(runner_pkg::DINO_HB_X_OFS);
	assign dino_r = dino_l + 10'(runner_pkg::DINO_HB_W);
	assign obs_l = 10'(obstacle_x);
	assign obs_r = obs_l + 10'(runner_pkg::OBS_SIZE);
	assign dino_t = 9'(dino_y) + 9'(runner_pkg::DINO_HB_Y_OFS);
	assign dino_b = dino_t + 9'(hb_h);
	assign obs_t = 9'(runner_pkg::OBS_Y);
	assign obs_b = obs_t + 9'(runner_pkg::OBS_SIZE);

	assign hit = (dino_r >= obs_l) && (dino_l <= obs_r) && (dino_b >= obs_t) && (dino_t <= obs_b);
	// Obstacle just moved past the dinosaur column
	assign crossing = (prev_x > runner_pkg::DINO_X) && (obstacle_x <= runner_pkg::DINO_X);

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			game_over <= 1'b0;
			game_over_q <= 1'b0;
			hit_q <= 1'b0;
			prev_x <= runner_pkg::SCREEN_W;
			respawn <= 1'b0;
			score <= '0;
		end else begin
			hit_q <= hit;
			prev_x <= obstacle_x;
			game_over_q <= game_over;
			respawn <= 1'b0;
			if (hit) begin
				game_over <= 1'b1;
			end
			if (!game_over && crossing && !hit && !hit_q) begin
				score <= score + 1'b1;
				respawn <= 1'b1;
			end
		end
	end

	// Best score survives rst_n
	always_ff @(posedge Clock) begin
		if (game_over && !game_over_q && score > best) begin
			best <= score;
		end
	end

	assign high_score = best;

endmodule

// ==== design/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx #(
	parameter int CLK_HZ = 50_000_000,
	parameter int BAUD = 115_200
) (
	input logic Clock,
	input logic rst_n,
	input logic rx_line,
	output logic byte_valid,
	output logic [7:0] byte_data
);

	localparam int DIV = CLK_HZ / (BAUD * 16);
	localparam int TW = $clog2(DIV);

	logic [TW-1:0] tick_cnt;
	logic tick;
	logic rx_meta;
	logic rx_sync;
	runner_pkg::rx_state_t state;
	logic [3:0] os_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift;

	// 16x oversampling tick
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			tick_cnt <= '0;
			tick <= 1'b0;
		end else begin
			tick <= (tick_cnt == TW'(DIV - 1));
			if (tick_cnt == TW'(DIV - 1)) begin
				tick_cnt <= '0;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	// Line idles high
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx_line;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			state <= runner_pkg::RX_IDLE;
			os_cnt <= '0;
			bit_idx <= '0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			if (tick) begin
				unique case (state)
					runner_pkg::RX_IDLE: begin
						// Wait half a bit before checking the start bit again
						if (!rx_sync) begin
							state <= runner_pkg::RX_START;
							os_cnt <= 4'd7;
						end
					end
					runner_pkg::RX_START: begin
						if (os_cnt != 4'd0) begin
							os_cnt <= os_cnt - 1'b1;
						end else if (!rx_sync) begin
							state <= runner_pkg::RX_DATA;
							os_cnt <= 4'd15;
							bit_idx <= '0;
						end else begin
							state <= runner_pkg::RX_IDLE;
						end
					end
					runner_pkg::RX_DATA: begin
						if (os_cnt != 4'd0) begin
							os_cnt <= os_cnt - 1'b1;
						end else begin
							shift[bit_idx] <= rx_sync;
							os_cnt <= 4'd15;
							if (bit_idx == 3'd7) begin
								state <= runner_pkg::RX_STOP;
							end else begin
								bit_idx <= bit_idx + 1'b1;
							end
						end
					end
					runner_pkg::RX_STOP: begin
						if (os_cnt != 4'd0) begin
							os_cnt <= os_cnt - 1'b1;
						end else begin
							byte_data <= shift;
							byte_valid <= 1'b1;
							state <= runner_pkg::RX_IDLE;
						end
					end
				endcase
			end
		end
	end

endmodule

// ==== design/world_scroller.sv ====
`timescale 1ns/1ns

module world_scroller #(
	parameter int STEP_DIV = 524_288
) (
	input logic Clock,
	input logic rst_n,
	input logic respawn,
	input logic game_over,
	output logic step,
	output runner_pkg::coord_x_t obstacle_x
);

	localparam int SDW = $clog2(STEP_DIV);
	localparam runner_pkg::coord_x_t WRAP_X =
		runner_pkg::coord_x_t'(runner_pkg::SCREEN_W - runner_pkg::OBS_SIZE);

	logic [SDW-1:0] div_cnt;
	logic [15:0] lfsr;
	logic feedback;
	runner_pkg::coord_x_t respawn_x;

	assign feedback = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];
	// Random extra distance so gaps between obstacles vary
	assign respawn_x = WRAP_X
		+ runner_pkg::coord_x_t'(lfsr[8:0] % runner_pkg::RESPAWN_SPAN);

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			div_cnt <= '0;
			step <= 1'b0;
			lfsr <= runner_pkg::LFSR_SEED;
			obstacle_x <= runner_pkg::SCREEN_W;
		end else if (game_over) begin
			step <= 1'b0;
		end else begin
			lfsr <= {lfsr[14:0], feedback};
			step <= (div_cnt == SDW'(STEP_DIV - 1));
			if (div_cnt == SDW'(STEP_DIV - 1)) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end

			if (respawn) begin
				obstacle_x <= respawn_x;
			end else if (step) begin
				if (obstacle_x <= runner_pkg::coord_x_t'(1)) begin
					obstacle_x <= WRAP_X;
				end else begin
					obstacle_x <= obstacle_x - 1'b1;
				end
			end
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module runner_tb \
	-f compile.f -o runner_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/runner_sim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "Simulation exited with an error status" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || grep -q "TEST PASSED" sim.log

// ==== tests/runner_assertions.sv ====
`timescale 1ns/1ns

module runner_assertions (
	input logic Clock,
	input logic rst_n,
	input logic game_over,
	input logic respawn,
	input runner_pkg::coord_x_t obstacle_x
);

	localparam int X_MAX = int'(runner_pkg::SCREEN_W) - int'(runner_pkg::OBS_SIZE)
		+ int'(runner_pkg::RESPAWN_SPAN) - 1;

	int fail_count = 0;

	// Game over is latched until the next reset
	game_over_latched: assert property (@(posedge Clock) $fell(game_over) |-> !$past(rst_n))
		else begin
			fail_count++;
			$error("game_over fell while rst_n was high");
		end

	no_respawn_after_crash: assert property (@(posedge Clock) disable iff (!rst_n)
		$rose(respawn) |-> !game_over)
		else begin
			fail_count++;
			$error("respawn rose while game_over was high");
		end

	// The reset value SCREEN_W already lies inside the respawn range
	obstacle_in_range: assert property (@(posedge Clock) disable iff (!rst_n)
		(int'(obstacle_x) <= X_MAX))
		else begin
			fail_count++;
			$error("obstacle_x %0d is beyond the respawn range", obstacle_x);
		end

endmodule

// ==== tests/runner_checker.sv ====
`timescale 1ns/1ns

module runner_checker #(
	parameter int DUCK_CYCLES = 2000
) (
	input logic Clock,
	input logic rst_n,
	input runner_pkg::coord_y_t dino_y,
	input runner_pkg::coord_x_t obstacle_x,
	input logic ducking,
	input logic game_over,
	input runner_pkg::hex_digits_t digits,
	input int test_id,
	input logic hold_ground,
	input logic hold_stand,
	output int error_count,
	output int check_count
);

	localparam int GROUND = int'(runner_pkg::GROUND_Y);
	localparam int WRAP_X = int'(runner_pkg::SCREEN_W) - int'(runner_pkg::OBS_SIZE);
	localparam int X_MAX = WRAP_X + int'(runner_pkg::RESPAWN_SPAN) - 1;

	int exp_score;
	int exp_best;
	logic exp_go;
	logic prev_go;
	logic prev_hit;
	logic prev_duck;
	int prev_x;
	int prev_y;
	logic after_reset;
	logic airborne;
	int lowest;
	int duck_len;
	logic duck_ok;
	int respawn_due;
	logic hit_now;

	function automatic string test_name(input int id);
		case (id)
			0: return "reset";
			1: return "uart_jump";
			2: return "key_jump";
			3: return "other_byte";
			4: return "duck";
			5: return "timed_jump";
			6: return "collision";
			default: return "high_score";
		endcase
	endfunction

	// Patterns listed active high as gfedcba, then inverted
	function automatic runner_pkg::seg7_t seg_ref(input int d);
		logic [6:0] lit;
		case (d)
			0: lit = 7'h3F;
			1: lit = 7'h06;
			2: lit = 7'h5B;
			3: lit = 7'h4F;
			4: lit = 7'h66;
			5: lit = 7'h6D;
			6: lit = 7'h7D;
			7: lit = 7'h07;
			8: lit = 7'h7F;
			default: lit = 7'h6F;
		endcase
		return ~lit;
	endfunction

	function automatic runner_pkg::hex_digits_t digits_ref(input int sc, input int hi);
		runner_pkg::hex_digits_t d;
		d.score_ones = seg_ref(sc % 10);
		d.score_tens = seg_ref((sc / 10) % 10);
		d.score_hundreds = seg_ref((sc / 100) % 10);
		d.high_ones = seg_ref(hi % 10);
		d.high_tens = seg_ref((hi / 10) % 10);
		d.high_hundreds = seg_ref((hi / 100) % 10);
		return d;
	endfunction

	// Peak of a jump, rows grow downward
	function automatic int lowest_jump_y();
		int y;
		int v;
		y = GROUND;
		v = int'(runner_pkg::JUMP_FORCE);
		while (v < 0) begin
			y = y + v;
			v = v + int'(runner_pkg::GRAVITY);
		end
		return y;
	endfunction

	function automatic logic boxes_touch(input int y, input int x, input logic duck);
		int dl;
		int dr;
		int dt;
		int db;
		dl = int'(runner_pkg::DINO_X) + int'(runner_pkg::DINO_HB_X_OFS);
		dr = dl + int'(runner_pkg::DINO_HB_W);
		dt = y + int'(runner_pkg::DINO_HB_Y_OFS);
		db = dt + (duck ? int'(runner_pkg::DINO_HB_H_DUCK) : int'(runner_pkg::DINO_HB_H));
		return (dr >= x) && (dl <= x + int'(runner_pkg::OBS_SIZE))
			&& (db >= int'(runner_pkg::OBS_Y))
			&& (dt <= int'(runner_pkg::OBS_Y) + int'(runner_pkg::OBS_SIZE));
	endfunction

	task automatic check_value(input string what, input int expected, input int actual,
		input int tol);
		check_count++;
		if (actual < expected - tol || actual > expected + tol) begin
			error_count++;
			$display("Fail %s: %s expected %0d actual %0d", test_name(test_id), what,
				expected, actual);
		end
	endtask

	task automatic check_digits(input runner_pkg::hex_digits_t expected);
		check_count++;
		if (digits !== expected) begin
			error_count++;
			$display("Fail %s: digits expected %h actual %h", test_name(test_id),
				expected, digits);
		end
	endtask

	initial begin
		error_count = 0;
		check_count = 0;
		exp_score = 0;
		exp_best = 0;
		exp_go = 1'b0;
		prev_go = 1'b0;
		prev_hit = 1'b0;
		prev_duck = 1'b0;
		after_reset = 1'b0;
		airborne = 1'b0;
		duck_ok = 1'b0;
		duck_len = 0;
		respawn_due = 0;
	end

	// Outputs settle after the rising edge, so everything is sampled on the falling one
	always @(negedge Clock) begin
		hit_now = boxes_touch(int'(dino_y), int'(obstacle_x), ducking);
		if (!rst_n) begin
			after_reset = 1'b1;
		end else if (after_reset) begin
			after_reset = 1'b0;
			check_value("game_over after reset", 0, int'(game_over), 0);
			check_value("ducking after reset", 0, int'(ducking), 0);
			check_value("dino_y after reset", GROUND, int'(dino_y), 0);
			check_value("obstacle_x after reset", int'(runner_pkg::SCREEN_W),
				int'(obstacle_x), 0);
			check_digits(digits_ref(0, exp_best));
		end else begin
			check_value("game_over", int'(exp_go), int'(game_over), 0);
			check_digits(digits_ref(exp_score, exp_best));
			if (prev_go && game_over) begin
				check_value("frozen obstacle_x", prev_x, int'(obstacle_x), 0);
				check_value("frozen dino_y", prev_y, int'(dino_y), 0);
			end
			if (ducking || hold_ground) begin
				check_value("dino_y on ground", GROUND, int'(dino_y), 0);
			end
			if (hold_stand) begin
				check_value("ducking", 0, int'(ducking), 0);
			end

			if (game_over) begin
				airborne = 1'b0;
			end else if (int'(dino_y) != GROUND) begin
				if (!airborne) begin
					airborne = 1'b1;
					lowest = int'(dino_y);
				end else if (int'(dino_y) < lowest) begin
					lowest = int'(dino_y);
				end
			end else if (airborne) begin
				check_value("lowest dino_y", lowest_jump_y(), lowest, 0);
				airborne = 1'b0;
			end

			if (ducking) begin
				if (!prev_duck) begin
					duck_len = 0;
					duck_ok = 1'b1;
				end
				duck_len++;
				if (game_over) begin
					duck_ok = 1'b0;
				end
			end else if (prev_duck && duck_ok) begin
				check_value("duck length", DUCK_CYCLES, duck_len, 4);
			end

			if (respawn_due > 0) begin
				if (int'(obstacle_x) >= WRAP_X && int'(obstacle_x) <= X_MAX) begin
					respawn_due = 0;
				end else begin
					respawn_due--;
					if (respawn_due == 0) begin
						error_count++;
						$display("Obstacle did not reappear in the respawn range during %s",
							test_name(test_id));
					end
				end
			end
		end

		// Best score follows the game over edge and ignores rst_n
		if (game_over && !prev_go && exp_score > exp_best) begin
			exp_best = exp_score;
		end
		if (!rst_n) begin
			exp_score = 0;
			exp_go = 1'b0;
			prev_go = 1'b0;
			prev_hit = 1'b0;
			prev_duck = 1'b0;
			prev_x = int'(runner_pkg::SCREEN_W);
			prev_y = GROUND;
			airborne = 1'b0;
			duck_ok = 1'b0;
			respawn_due = 0;
		end else begin
			if (!game_over && prev_x > int'(runner_pkg::DINO_X)
				&& int'(obstacle_x) <= int'(runner_pkg::DINO_X)
				&& !hit_now && !prev_hit) begin
				exp_score++;
				respawn_due = 3;
			end
			exp_go = exp_go | hit_now;
			prev_go = game_over;
			prev_hit = hit_now;
			prev_duck = ducking;
			prev_x = int'(obstacle_x);
			prev_y = int'(dino_y);
		end
	end

endmodule

// ==== tests/runner_tb.sv ====
`timescale 1ns/1ns

module runner_tb;

	localparam int CLK_HZ = 1_600_000;
	localparam int BAUD = 10_000;
	localparam int STEP_DIV = 64;
	localparam int DUCK_CYCLES = 2000;
	localparam int BIT_CLKS = CLK_HZ / BAUD;
	// Covers six full obstacle scrolls at one step per STEP_DIV clocks
	localparam int MAX_CYCLES = 200_000;

	logic Clock;
	logic rst_n;
	logic uart_rx_line;
	logic jump_key;
	logic duck_key;
	runner_pkg::coord_y_t dino_y;
	runner_pkg::coord_x_t obstacle_x;
	logic ducking;
	logic game_over;
	runner_pkg::hex_digits_t digits;
	int test_id;
	logic hold_ground;
	logic hold_stand;
	int error_count;
	int check_count;
	int cycle_count;

	runner_top #(
		.CLK_HZ(CLK_HZ),
		.BAUD(BAUD),
		.STEP_DIV(STEP_DIV),
		.DUCK_CYCLES(DUCK_CYCLES)
	) u_runner_top (
		.Clock(Clock),
		.rst_n(rst_n),
		.uart_rx_line(uart_rx_line),
		.jump_key(jump_key),
		.duck_key(duck_key),
		.dino_y(dino_y),
		.obstacle_x(obstacle_x),
		.ducking(ducking),
		.game_over(game_over),
		.digits(digits)
	);

	runner_checker #(
		.DUCK_CYCLES(DUCK_CYCLES)
	) u_checker (
		.Clock(Clock),
		.rst_n(rst_n),
		.dino_y(dino_y),
		.obstacle_x(obstacle_x),
		.ducking(ducking),
		.game_over(game_over),
		.digits(digits),
		.test_id(test_id),
		.hold_ground(hold_ground),
		.hold_stand(hold_stand),
		.error_count(error_count),
		.check_count(check_count)
	);

	bind runner_top runner_assertions u_runner_assertions (
		.Clock(Clock),
		.rst_n(rst_n),
		.game_over(game_over),
		.respawn(respawn),
		.obstacle_x(obstacle_x)
	);

	initial begin
		Clock = 1'b0;
		forever #20 Clock = ~Clock;
	end

	task automatic print_counts();
		$display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count,
			error_count, u_runner_top.u_runner_assertions.fail_count);
	endtask

	always @(posedge Clock) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			print_counts();
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic apply_reset();
		@(negedge Clock);
		rst_n = 1'b0;
		repeat (4) @(negedge Clock);
		rst_n = 1'b1;
	endtask

	// 8N1 frame sent LSB first
	task automatic send_byte(input logic [7:0] b);
		@(negedge Clock);
		uart_rx_line = 1'b0;
		repeat (BIT_CLKS) @(negedge Clock);
		for (int i = 0; i < 8; i++) begin
			uart_rx_line = b[i];
			repeat (BIT_CLKS) @(negedge Clock);
		end
		uart_rx_line = 1'b1;
		repeat (BIT_CLKS) @(negedge Clock);
	endtask

	task automatic press_jump_key();
		@(negedge Clock);
		jump_key = 1'b1;
		repeat (8) @(negedge Clock);
		jump_key = 1'b0;
	endtask

	task automatic idle_gap();
		repeat ($urandom_range(120, 20)) @(negedge Clock);
	endtask

	task automatic wait_full_jump();
		while (dino_y == runner_pkg::GROUND_Y) @(negedge Clock);
		while (dino_y != runner_pkg::GROUND_Y) @(negedge Clock);
	endtask

	initial begin
		void'($urandom(21932));
		cycle_count = 0;
		rst_n = 1'b0;
		uart_rx_line = 1'b1;
		jump_key = 1'b0;
		duck_key = 1'b0;
		hold_ground = 1'b0;
		hold_stand = 1'b0;
		test_id = 0;
		apply_reset();
		idle_gap();

		test_id = 1;
		send_byte("J");
		wait_full_jump();
		idle_gap();

		test_id = 2;
		press_jump_key();
		wait_full_jump();
		idle_gap();

		test_id = 3;
		hold_ground = 1'b1;
		hold_stand = 1'b1;
		send_byte("X");
		repeat (200) @(negedge Clock);
		hold_stand = 1'b0;
		hold_ground = 1'b0;
		idle_gap();

		// A jump sent mid-duck must be ignored
		test_id = 4;
		send_byte("D");
		while (!ducking) @(negedge Clock);
		hold_ground = 1'b1;
		send_byte("J");
		while (ducking) @(negedge Clock);
		repeat (100) @(negedge Clock);
		hold_ground = 1'b0;

		test_id = 5;
		apply_reset();
		while (obstacle_x != runner_pkg::DINO_X + 9'd36) @(negedge Clock);
		press_jump_key();
		while (!game_over && obstacle_x > runner_pkg::DINO_X) @(negedge Clock);
		repeat (200) @(negedge Clock);

		test_id = 6;
		apply_reset();
		while (!game_over) @(negedge Clock);
		repeat (500) @(negedge Clock);

		test_id = 7;
		apply_reset();
		repeat (50) @(negedge Clock);

		print_counts();
		if (error_count == 0 && u_runner_top.u_runner_assertions.fail_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
